//--- rtl/tinker_pkg.sv
// Tinker core shared definitions
`default_nettype none

package tinker_pkg;

    // --------------------------------------------------
    // Widths and sizes
    // --------------------------------------------------
    localparam int XLEN      = 64;        // Data word
    localparam int ILEN      = 32;        // Instruction word
    localparam int ADDR_W    = 32;        // PC and byte addresses
    localparam int REG_AW    = 5;         // Register index
    localparam int NUM_REGS  = 32;
    localparam int LIT_W     = 12;        // Literal field
    localparam int MEM_BYTES = 16384;
    localparam int MEM_AW    = $clog2(MEM_BYTES); // Addresses wrap at this width

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_2000;

    // --------------------------------------------------
    // Opcodes, encoded in bits 31:27
    // --------------------------------------------------
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR_R  = 5'h09,  // PC relative, offset in rd
        OP_BRR_L  = 5'h0a,  // PC relative, offset in L
        OP_BRNZ   = 5'h0b,
        OP_BRGT   = 5'h0e,
        OP_HALT   = 5'h0f,
        OP_LD     = 5'h10,
        OP_MOV_RR = 5'h11,
        OP_MOV_RL = 5'h12,
        OP_ST     = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    // One state per instruction phase, plus the sticky halt
    typedef enum logic [2:0] {
        S_FETCH     = 3'd0,
        S_DECODE    = 3'd1,
        S_EXECUTE   = 3'd2,
        S_MEMORY    = 3'd3,
        S_WRITEBACK = 3'd4,
        S_HALT      = 3'd5
    } state_t;

endpackage

`default_nettype wire

//--- rtl/tinker_alu.sv
// Tinker integer ALU
`default_nettype none

module tinker_alu (
    input  tinker_pkg::opcode_t               opcode,
    input  logic [tinker_pkg::XLEN-1:0]       op_a,    // rs
    input  logic [tinker_pkg::XLEN-1:0]       op_b,    // rt
    input  logic [tinker_pkg::XLEN-1:0]       op_d,    // rd
    input  logic [tinker_pkg::LIT_W-1:0]      lit,
    output logic [tinker_pkg::XLEN-1:0]       result
);
    import tinker_pkg::*;

    logic [XLEN-1:0] lit_sx;  // Sign extended literal
    logic [XLEN-1:0] lit_zx;  // Zero extended literal

    assign lit_sx = {{(XLEN-LIT_W){lit[LIT_W-1]}}, lit};
    assign lit_zx = {{(XLEN-LIT_W){1'b0}}, lit};

    always_comb begin
        case (opcode)
            // Register-register arithmetic
            OP_ADD:    result = op_a + op_b;
            OP_SUB:    result = op_a - op_b;
            OP_MUL:    result = op_a * op_b;   // Low 64 bits kept
            // Immediate forms work on rd in place
            OP_ADDI:   result = op_d + lit_sx;
            OP_SUBI:   result = op_d - lit_zx; // Literal is unsigned here
            // Logic
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;         // rt unused
            // Shifts, logical only
            OP_SHFTR:  result = op_a >> op_b;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTRI: result = op_d >> lit;
            OP_SHFTLI: result = op_d << lit;
            // Moves
            OP_MOV_RR: result = op_a;
            OP_MOV_RL: result = {op_d[XLEN-1:LIT_W], lit}; // Upper bits of rd kept
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/tinker_regfile.sv
// Tinker register file
`default_nettype none

module tinker_regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                we,
    input  logic [tinker_pkg::REG_AW-1:0]       wa,
    input  logic [tinker_pkg::XLEN-1:0]         wd,
    input  logic [tinker_pkg::REG_AW-1:0]       ra_a,   // rs
    input  logic [tinker_pkg::REG_AW-1:0]       ra_b,   // rt
    input  logic [tinker_pkg::REG_AW-1:0]       ra_d,   // rd
    input  logic [tinker_pkg::REG_AW-1:0]       ra_dbg,
    output logic [tinker_pkg::XLEN-1:0]         rd_a,
    output logic [tinker_pkg::XLEN-1:0]         rd_b,
    output logic [tinker_pkg::XLEN-1:0]         rd_d,
    output logic [tinker_pkg::XLEN-1:0]         rd_dbg
);
    import tinker_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // All registers start at zero, r31 included
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Combinational reads
    assign rd_a   = regs[ra_a];
    assign rd_b   = regs[ra_b];
    assign rd_d   = regs[ra_d];
    assign rd_dbg = regs[ra_dbg]; // Observation only

    // Control must keep writes off while the core is held in reset
    a_no_write_in_reset: assert property (@(posedge clk) !(reset && we))
        else $error("register write during reset");

endmodule

`default_nettype wire

//--- rtl/tinker_memory.sv
// Tinker unified byte memory
`default_nettype none

module tinker_memory (
    input  logic                                clk,
    input  logic [tinker_pkg::ADDR_W-1:0]       fetch_addr,
    output logic [tinker_pkg::ILEN-1:0]         instr_word,
    input  logic [tinker_pkg::ADDR_W-1:0]       load_addr,
    output logic [tinker_pkg::XLEN-1:0]         load_data,
    input  logic                                store_we,
    input  logic [tinker_pkg::ADDR_W-1:0]       store_addr,
    input  logic [tinker_pkg::XLEN-1:0]         store_data,
    input  logic                                prog_we,
    input  logic [tinker_pkg::ADDR_W-1:0]       prog_addr,
    input  logic [tinker_pkg::ILEN-1:0]         prog_data
);
    import tinker_pkg::*;

    logic [7:0] mem [MEM_BYTES];  // No reset, contents come from program load

    // --------------------------------------------------
    // Reads, big-endian, most significant byte first
    // --------------------------------------------------
    always_comb begin
        for (int k = 0; k < ILEN / 8; k++) begin
            instr_word[ILEN-1-8*k -: 8] = mem[MEM_AW'(fetch_addr + k)];
        end
        for (int k = 0; k < XLEN / 8; k++) begin
            load_data[XLEN-1-8*k -: 8] = mem[MEM_AW'(load_addr + k)];
        end
    end

    // --------------------------------------------------
    // Writes
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (store_we) begin
            for (int k = 0; k < XLEN / 8; k++) begin
                mem[MEM_AW'(store_addr + k)] <= store_data[XLEN-1-8*k -: 8];
            end
        end else if (prog_we) begin  // 32-bit program word
            for (int k = 0; k < ILEN / 8; k++) begin
                mem[MEM_AW'(prog_addr + k)] <= prog_data[ILEN-1-8*k -: 8];
            end
        end
    end

    // Program loading happens only while the core is idle in reset
    a_single_writer: assert property (@(posedge clk) !(store_we && prog_we))
        else $error("store and program load in the same cycle");

endmodule

`default_nettype wire

//--- rtl/tinker_control.sv
// Tinker decode and control
`default_nettype none

module tinker_control (
    input  logic                                clk,
    input  logic                                reset,
    input  tinker_pkg::state_t                  state,
    input  logic [tinker_pkg::ADDR_W-1:0]       pc,
    input  logic [tinker_pkg::ILEN-1:0]         instr_word,
    input  logic [tinker_pkg::XLEN-1:0]         op_a,       // rs value
    input  logic [tinker_pkg::XLEN-1:0]         op_b,       // rt value
    input  logic [tinker_pkg::XLEN-1:0]         op_d,       // rd value
    input  logic [tinker_pkg::XLEN-1:0]         alu_result,
    input  logic [tinker_pkg::XLEN-1:0]         load_data,
    output tinker_pkg::opcode_t                 opcode,
    output logic [tinker_pkg::LIT_W-1:0]        lit,
    output logic [tinker_pkg::REG_AW-1:0]       rs,
    output logic [tinker_pkg::REG_AW-1:0]       rt,
    output logic [tinker_pkg::REG_AW-1:0]       rd,
    output logic                                halt_decoded,
    output logic                                pc_load,
    output logic [tinker_pkg::ADDR_W-1:0]       next_pc,
    output logic [tinker_pkg::ADDR_W-1:0]       load_addr,
    output logic                                store_we,
    output logic [tinker_pkg::ADDR_W-1:0]       store_addr,
    output logic [tinker_pkg::XLEN-1:0]         store_data,
    output logic                                rf_we,
    output logic [tinker_pkg::REG_AW-1:0]       rf_wa,
    output logic [tinker_pkg::XLEN-1:0]         rf_wd
);
    import tinker_pkg::*;

    logic [ILEN-1:0] ir;        // Instruction register
    logic [XLEN-1:0] result_q;  // ALU or load result, held for writeback
    logic [XLEN-1:0] lit_sx;
    logic [XLEN-1:0] ld_ea;     // rs + L
    logic [XLEN-1:0] st_ea;     // rd + L
    logic            writes_rd;

    // --------------------------------------------------
    // Instruction register and field decode
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (state == S_FETCH) begin
            ir <= instr_word;
        end
    end

    assign opcode = opcode_t'(ir[31:27]);
    assign rd     = ir[26:22];
    assign rs     = ir[21:17];
    assign rt     = ir[16:12];
    assign lit    = ir[LIT_W-1:0];
    assign lit_sx = {{(XLEN-LIT_W){lit[LIT_W-1]}}, lit};

    assign halt_decoded = (opcode == OP_HALT); // Sampled by the sequencer in DECODE

    // EXECUTE captures the ALU result and MEMORY overrides it for loads
    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) begin
            result_q <= alu_result;
        end else if (state == S_MEMORY && opcode == OP_LD) begin
            result_q <= load_data;
        end
    end

    // --------------------------------------------------
    // Branch resolution
    // --------------------------------------------------
    always_comb begin
        next_pc = pc + 4;  // Also covers dropped and undefined opcodes
        case (opcode)
            OP_BR:    next_pc = op_d[ADDR_W-1:0];
            OP_BRR_R: next_pc = pc + op_d[ADDR_W-1:0];
            OP_BRR_L: next_pc = pc + lit_sx[ADDR_W-1:0];
            OP_BRNZ:  if (op_a != '0) next_pc = op_d[ADDR_W-1:0];
            OP_BRGT:  if ($signed(op_a) > $signed(op_b)) next_pc = op_d[ADDR_W-1:0];
            default:  ;
        endcase
    end

    assign pc_load = (state == S_WRITEBACK);

    // --------------------------------------------------
    // Memory strobes
    // --------------------------------------------------
    assign ld_ea      = op_a + lit_sx;
    assign st_ea      = op_d + lit_sx;
    assign load_addr  = ld_ea[ADDR_W-1:0];
    assign store_addr = st_ea[ADDR_W-1:0];
    assign store_data = op_a;                 // rs is the stored value
    assign store_we   = (state == S_MEMORY) && (opcode == OP_ST);

    // Register writeback for ALU ops and loads
    assign writes_rd = opcode inside {OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
                                      OP_AND, OP_OR, OP_XOR, OP_NOT,
                                      OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
                                      OP_MOV_RR, OP_MOV_RL, OP_LD};
    assign rf_we = (state == S_WRITEBACK) && writes_rd;
    assign rf_wa = rd;
    assign rf_wd = result_q;

    // Single-cycle strobes, each followed by the next phase
    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        store_we |=> state == S_WRITEBACK) else $error("store not followed by WRITEBACK");
    a_write_in_wb: assert property (@(posedge clk) disable iff (reset)
        rf_we |=> state == S_FETCH) else $error("register write not followed by FETCH");

endmodule

`default_nettype wire

//--- rtl/tinker_sequencer.sv
// Tinker state sequencer and PC
`default_nettype none

module tinker_sequencer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                halt_decoded,
    input  logic                                pc_load,
    input  logic [tinker_pkg::ADDR_W-1:0]       next_pc,
    output tinker_pkg::state_t                  state,
    output logic [tinker_pkg::ADDR_W-1:0]       pc,
    output logic                                hlt
);
    import tinker_pkg::*;

    state_t state_nx;

    always_comb begin
        case (state)
            S_FETCH:     state_nx = S_DECODE;
            S_DECODE:    state_nx = halt_decoded ? S_HALT : S_EXECUTE;
            S_EXECUTE:   state_nx = S_MEMORY;
            S_MEMORY:    state_nx = S_WRITEBACK;
            S_WRITEBACK: state_nx = S_FETCH;
            default:     state_nx = S_HALT;  // Left only through reset
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_nx;
            if (pc_load) pc <= next_pc;   // End of WRITEBACK only
        end
    end

    assign hlt = (state == S_HALT);

    a_legal_state: assert property (@(posedge clk) disable iff (reset)
        state inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALT})
        else $error("illegal sequencer state %0d", state);

endmodule

`default_nettype wire

//--- rtl/tinker_core.sv
// Tinker core top level
`default_nettype none

module tinker_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                prog_we,
    input  logic [tinker_pkg::ADDR_W-1:0]       prog_addr,
    input  logic [tinker_pkg::ILEN-1:0]         prog_data,
    input  logic [tinker_pkg::REG_AW-1:0]       dbg_reg,
    output logic [tinker_pkg::XLEN-1:0]         dbg_data,
    output logic [tinker_pkg::ADDR_W-1:0]       pc,
    output logic                                hlt
);
    import tinker_pkg::*;

    // --------------------------------------------------
    // Interconnect
    // --------------------------------------------------
    state_t            state;
    opcode_t           opcode;
    logic              halt_decoded, pc_load;
    logic [ADDR_W-1:0] next_pc, load_addr, store_addr;
    logic [ILEN-1:0]   instr_word;
    logic [XLEN-1:0]   op_a, op_b, op_d, alu_result, load_data, store_data;
    logic [LIT_W-1:0]  lit;
    logic [REG_AW-1:0] rs, rt, rd, rf_wa;
    logic              store_we, rf_we;
    logic [XLEN-1:0]   rf_wd;

    tinker_sequencer u_seq (
        .clk(clk), .reset(reset), .halt_decoded(halt_decoded),
        .pc_load(pc_load), .next_pc(next_pc),
        .state(state), .pc(pc), .hlt(hlt)
    );

    tinker_control u_ctrl (
        .clk(clk), .reset(reset), .state(state), .pc(pc),
        .instr_word(instr_word), .op_a(op_a), .op_b(op_b), .op_d(op_d),
        .alu_result(alu_result), .load_data(load_data),
        .opcode(opcode), .lit(lit), .rs(rs), .rt(rt), .rd(rd),
        .halt_decoded(halt_decoded), .pc_load(pc_load), .next_pc(next_pc),
        .load_addr(load_addr), .store_we(store_we), .store_addr(store_addr),
        .store_data(store_data), .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd)
    );

    tinker_alu u_alu (
        .opcode(opcode), .op_a(op_a), .op_b(op_b), .op_d(op_d),
        .lit(lit), .result(alu_result)
    );

    // Fixed read ports, rs on A, rt on B, rd on D
    tinker_regfile u_rf (
        .clk(clk), .reset(reset), .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .ra_a(rs), .ra_b(rt), .ra_d(rd), .ra_dbg(dbg_reg),
        .rd_a(op_a), .rd_b(op_b), .rd_d(op_d), .rd_dbg(dbg_data)
    );

    tinker_memory u_mem (
        .clk(clk), .fetch_addr(pc), .instr_word(instr_word),
        .load_addr(load_addr), .load_data(load_data),
        .store_we(store_we), .store_addr(store_addr), .store_data(store_data),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
    );

endmodule

`default_nettype wire

//--- include/tinker_tb_isa.svh
// Tinker encoders and reference model
`ifndef TINKER_TB_ISA_SVH
`define TINKER_TB_ISA_SVH

// Packs opcode, rd, rs, rt and L
function automatic logic [31:0] enc(input tinker_pkg::opcode_t op, input logic [4:0] rd,
                                    input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [11:0] lit);
    return {op, rd, rs, rt, lit};
endfunction

// rd and literal only for immediates, mov rd,L and brr L
function automatic logic [31:0] enc_l(input tinker_pkg::opcode_t op, input logic [4:0] rd,
                                      input logic [11:0] lit);
    return enc(op, rd, 5'd0, 5'd0, lit);
endfunction

function automatic logic [63:0] sext12(input logic [11:0] lit);
    return {{52{lit[11]}}, lit};
endfunction

// Expected rd value from a = rs, b = rt and d = old rd
function automatic logic [63:0] model_alu(input tinker_pkg::opcode_t op,
                                          input logic [63:0] a, input logic [63:0] b,
                                          input logic [63:0] d, input logic [11:0] lit);
    case (op)
        tinker_pkg::OP_ADD:    return a + b;
        tinker_pkg::OP_SUB:    return a - b;
        tinker_pkg::OP_MUL:    return a * b;
        tinker_pkg::OP_ADDI:   return d + sext12(lit);
        tinker_pkg::OP_SUBI:   return d - {52'd0, lit};
        tinker_pkg::OP_AND:    return a & b;
        tinker_pkg::OP_OR:     return a | b;
        tinker_pkg::OP_XOR:    return a ^ b;
        tinker_pkg::OP_NOT:    return ~a;
        tinker_pkg::OP_SHFTR:  return a >> b;
        tinker_pkg::OP_SHFTL:  return a << b;
        tinker_pkg::OP_SHFTRI: return d >> lit;
        tinker_pkg::OP_SHFTLI: return d << lit;
        tinker_pkg::OP_MOV_RR: return a;
        tinker_pkg::OP_MOV_RL: return {d[63:12], lit};
        default:               return d;  // Non-writing opcodes leave rd alone
    endcase
endfunction

`endif

//--- verif/tinker_tb.sv
// Tinker core testbench
`default_nettype none

module tinker_tb;
    import tinker_pkg::*;

    `include "tinker_tb_isa.svh"

    // --------------------------------------------------
    // Run limits
    // --------------------------------------------------
    localparam int NUM_TESTS = 6;
    localparam int MAX_INSTR = 24;                // Longest program with its halt
    localparam int RESET_CYC = 8;
    localparam int NUM_CHECK = 16;                // Registers read back per test
    localparam int RUN_LIMIT = 5 * MAX_INSTR + 10;
    // Reset and load, run and reads plus slack for the halt hold and second reset
    localparam int TIMEOUT = NUM_TESTS * (RESET_CYC + MAX_INSTR + RUN_LIMIT + NUM_CHECK + 40);

    logic              clk;
    logic              reset;
    logic              prog_we;
    logic [ADDR_W-1:0] prog_addr;
    logic [ILEN-1:0]   prog_data;
    logic [REG_AW-1:0] dbg_reg;
    logic [XLEN-1:0]   dbg_data;
    logic [ADDR_W-1:0] pc;
    logic              hlt;

    integer      seed = 41318;
    int          cycles = 0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    int          checks_at;
    int          errors_at;
    string       test_name;
    logic [31:0] prog [$];                        // Program under construction
    logic [63:0] mdl [NUM_REGS];                  // Expected register file

    opcode_t arith_ops [3] = '{OP_ADD, OP_SUB, OP_MUL};
    opcode_t logic_ops [7] = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTL, OP_MOV_RR};

    tinker_core uut (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .dbg_reg(dbg_reg), .dbg_data(dbg_data),
        .pc(pc), .hlt(hlt)
    );

    always #10 clk = ~clk;

    // Hard stop if a program never halts
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: no end of run after %0d cycles", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Program building and model update
    // --------------------------------------------------
    function automatic logic [11:0] rand_lit();
        return 12'($random(seed));
    endfunction

    // Straight-line instruction that the model follows
    task automatic emit(input opcode_t op, input int rd, input int rs, input int rt,
                        input logic [11:0] lit);
        prog.push_back(enc(op, 5'(rd), 5'(rs), 5'(rt), lit));
        mdl[rd] = model_alu(op, mdl[rs], mdl[rt], mdl[rd], lit);
    endtask

    // Marker write kept out of the model when the branch skips it
    task automatic marker(input int r, input bit skipped);
        if (skipped) begin
            prog.push_back(enc_l(OP_MOV_RL, 5'(r), 12'h0ad));
        end else begin
            emit(OP_MOV_RL, r, 0, 0, 12'h0ad);
        end
    endtask

    // Wide random r1 and masked random r2
    task automatic build_operands(input logic [11:0] mask);
        emit(OP_MOV_RL, 1, 0, 0, rand_lit());
        emit(OP_SHFTLI, 1, 0, 0, 12'd37);
        emit(OP_MOV_RL, 1, 0, 0, rand_lit());
        emit(OP_MOV_RL, 2, 0, 0, rand_lit() & mask);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        checks_at = checks;
        errors_at = errors;
        tests++;
        prog.delete();
        foreach (mdl[i]) mdl[i] = '0;             // Registers clear on reset
    endtask

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_CHECK; r++) begin
            @(posedge clk);
            #2 dbg_reg = 5'(r);
            @(negedge clk);                        // dbg_data settled
            check_val($sformatf("r%0d", r), mdl[r], dbg_data);
        end
    endtask

    // Load under reset then release and wait for hlt
    task automatic run_program();
        int n;
        int waited;
        emit(OP_HALT, 0, 0, 0, 0);
        n = prog.size();
        @(posedge clk);
        #2 reset = 1;
        for (int i = 0; i < ((n > RESET_CYC) ? n : RESET_CYC); i++) begin
            prog_we   = (i < n);
            prog_addr = RESET_PC + 4 * i;
            prog_data = (i < n) ? prog[i] : '0;
            @(posedge clk);
            #2;
        end
        prog_we = 0;
        reset   = 0;
        waited  = 0;
        while (!hlt && waited < RUN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (hlt) else begin
            $display("%s: hlt did not rise within %0d cycles", test_name, RUN_LIMIT);
            errors++;
        end
        check_val("pc at halt", RESET_PC + 4 * (n - 1), pc);
    endtask

    task automatic finish_test();
        $display("%-18s checks %0d errors %0d", test_name, checks - checks_at, errors - errors_at);
    endtask

    task automatic branch_test(input string name, input bit taken);
        start_test(name);
        emit(OP_MOV_RL, 1, 0, 0, 12'd1);
        emit(OP_SHFTLI, 1, 0, 0, 12'd13);          // r1 = 0x2000
        emit(OP_MOV_RR, 2, 1, 0, 0);
        emit(OP_MOV_RL, 2, 0, 0, taken ? 12'h018 : 12'h014);
        emit(OP_BR, 2, 0, 0, 0);
        marker(10, taken);
        emit(OP_BRR_L, 0, 0, 0, taken ? 12'd8 : 12'd4);
        marker(11, taken);
        emit(OP_MOV_RL, 3, 0, 0, taken ? 12'd8 : 12'd4);
        emit(OP_BRR_R, 3, 0, 0, 0);
        marker(12, taken);
        emit(OP_MOV_RR, 5, 1, 0, 0);
        emit(OP_MOV_RL, 5, 0, 0, 12'h03c);         // Lands on the NOT
        emit(OP_BRNZ, 5, taken ? 1 : 0, 0, 0);
        marker(13, taken);
        emit(OP_NOT, 7, 0, 0, 0);                  // r7 = -1
        emit(OP_MOV_RL, 4, 0, 0, 12'd5);
        emit(OP_MOV_RL, 5, 0, 0, 12'h050);         // Lands on the halt
        emit(OP_BRGT, 5, taken ? 4 : 7, taken ? 7 : 4, 0); // Signed compare of 5 and -1
        marker(14, taken);
        run_program();
        check_regs();
        finish_test();
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        clk       = 0;
        reset     = 1;
        prog_we   = 0;
        prog_addr = '0;
        prog_data = '0;
        dbg_reg   = '0;

        start_test("arith");
        build_operands(12'hfff);
        foreach (arith_ops[i]) begin
            emit(arith_ops[i], 3 + i, 1, 2, 0);
        end
        emit(OP_ADDI, 1, 0, 0, rand_lit());        // Sign extended literal
        emit(OP_SUBI, 2, 0, 0, rand_lit());
        run_program();
        check_regs();
        finish_test();

        start_test("logic_shift");
        build_operands(12'h03f);                   // r2 is a shift amount
        foreach (logic_ops[i]) begin
            emit(logic_ops[i], 3 + i, 1, 2, 0);
        end
        emit(OP_SHFTRI, 1, 0, 0, rand_lit() & 12'h03f);
        emit(OP_SHFTLI, 2, 0, 0, rand_lit() & 12'h03f);
        run_program();
        check_regs();
        finish_test();

        start_test("memory");
        build_operands(12'hfff);
        emit(OP_MOV_RL, 3, 0, 0, 12'h800);         // Data base
        emit(OP_ST, 3, 1, 0, 12'h000);             // mem[0x800] = r1
        emit(OP_ST, 3, 2, 0, 12'h010);             // mem[0x810] = r2
        emit(OP_LD, 4, 3, 0, 12'h000);
        mdl[4] = mdl[1];
        emit(OP_LD, 5, 3, 0, 12'h010);
        mdl[5] = mdl[2];
        emit(OP_MOV_RL, 6, 0, 0, 12'h820);
        emit(OP_LD, 7, 6, 0, 12'hff0);             // 0x820 - 16
        mdl[7] = mdl[2];
        run_program();
        check_regs();
        finish_test();

        branch_test("branch_taken", 1'b1);
        branch_test("branch_not_taken", 1'b0);

        start_test("halt");
        build_operands(12'hfff);
        emit(opcode_t'(5'h1d), 1, 1, 2, 0);        // Former div opcode acts as a no-op
        run_program();
        check_regs();
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_val("pc held", RESET_PC + 4 * (prog.size() - 1), pc);
        check_val("hlt held", 1, hlt);
        check_regs();
        @(posedge clk);
        #2 reset = 1;
        @(negedge clk);
        check_val("hlt after reset", 0, hlt);
        check_val("pc after reset", RESET_PC, pc);
        foreach (mdl[i]) mdl[i] = '0;
        check_regs();
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
rtl/tinker_pkg.sv
rtl/tinker_alu.sv
rtl/tinker_regfile.sv
rtl/tinker_memory.sv
rtl/tinker_control.sv
rtl/tinker_sequencer.sv
rtl/tinker_core.sv
verif/tinker_tb.sv
